//--- files.f
source/mem_types_pkg.sv
source/bridge_if_pkg.sv
source/burst_ctrl.sv
source/write_credit_counter.sv
source/line_assembler.sv
source/line_splitter.sv
source/burst_bridge_top.sv
tb/burst_mem_model.sv
tb/tb_burst_bridge.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns -f files.f \
    --top-module tb_burst_bridge -o sim_burst_bridge &&
./obj_dir/sim_burst_bridge | tee /dev/stderr | grep -q "TEST PASS" ||
exit 1

//--- source/bridge_if_pkg.sv
package bridge_if_pkg;

    // cache side request, one line at a time
    typedef struct packed {
        logic                 valid;
        logic                 write;
        mem_types_pkg::addr_t addr;
        mem_types_pkg::line_t wdata;
    } line_req_t;

    // one cycle response pulse, rdata only meaningful after a read
    typedef struct packed {
        logic                 valid;
        mem_types_pkg::line_t rdata;
    } line_resp_t;

    // burst command, addr is line aligned
    typedef struct packed {
        logic                 valid;
        logic                 write;
        mem_types_pkg::addr_t addr;
    } mem_cmd_t;

    typedef struct packed {
        logic                 valid;
        mem_types_pkg::beat_t data;
    } mem_wbeat_t;

    typedef struct packed {
        logic                 valid;
        mem_types_pkg::beat_t data;
    } mem_rbeat_t;

    typedef enum logic [2:0] {
        idle,
        rd_cmd,
        rd_beats,
        wr_cmd,
        wr_beats,
        respond
    } ctrl_state_t;

endpackage

//--- source/burst_bridge_top.sv
module burst_bridge_top (
    input  logic                      clk,
    input  logic                      rst,
    input  bridge_if_pkg::line_req_t  req,
    output logic                      req_ready,
    output bridge_if_pkg::line_resp_t resp,
    output bridge_if_pkg::mem_cmd_t   cmd,
    output bridge_if_pkg::mem_wbeat_t wbeat,
    input  logic                      credit_return,
    input  bridge_if_pkg::mem_rbeat_t rbeat
);
    mem_types_pkg::beat_idx_t beat_idx;
    mem_types_pkg::beat_t     beat_data;
    mem_types_pkg::line_t     rdata;
    logic                     wbeat_valid;
    logic                     credit_avail;
    logic                     line_load;
    logic                     resp_valid;

    burst_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_ready    (req_ready),
        .cmd          (cmd),
        .rbeat_valid  (rbeat.valid),
        .wbeat_valid  (wbeat_valid),
        .credit_avail (credit_avail),
        .beat_idx     (beat_idx),
        .line_load    (line_load),
        .resp_valid   (resp_valid)
    );

    write_credit_counter u_credits (
        .clk           (clk),
        .rst           (rst),
        .spend         (wbeat_valid), // every valid beat is taken by memory
        .credit_return (credit_return),
        .credit_avail  (credit_avail)
    );

    line_assembler u_assembler (
        .clk      (clk),
        .rst      (rst),
        .rbeat    (rbeat),
        .beat_idx (beat_idx),
        .rdata    (rdata)
    );

    line_splitter u_splitter (
        .clk       (clk),
        .rst       (rst),
        .line_load (line_load),
        .wdata     (req.wdata),
        .beat_idx  (beat_idx),
        .beat_data (beat_data)
    );

    assign wbeat.valid = wbeat_valid;
    assign wbeat.data  = beat_data;

    assign resp.valid = resp_valid;
    assign resp.rdata = rdata;

endmodule

//--- source/burst_ctrl.sv
module burst_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  bridge_if_pkg::line_req_t  req,
    output logic                      req_ready,
    output bridge_if_pkg::mem_cmd_t   cmd,
    input  logic                      rbeat_valid,
    output logic                      wbeat_valid,
    input  logic                      credit_avail,
    output mem_types_pkg::beat_idx_t  beat_idx,
    output logic                      line_load,
    output logic                      resp_valid
);
    bridge_if_pkg::ctrl_state_t state;
    bridge_if_pkg::ctrl_state_t state_next;
    mem_types_pkg::addr_t       line_addr;
    logic                       beat_step;
    logic                       last_beat;

    assign req_ready  = (state == bridge_if_pkg::idle);
    assign line_load  = req_ready && req.valid;
    assign resp_valid = (state == bridge_if_pkg::respond);

    // a write beat only goes out while a credit is held
    assign wbeat_valid = (state == bridge_if_pkg::wr_beats) && credit_avail;

    assign beat_step = ((state == bridge_if_pkg::rd_beats) && rbeat_valid) || wbeat_valid;
    assign last_beat = (beat_idx ==
                        mem_types_pkg::beat_idx_t'(mem_types_pkg::BEATS_PER_LINE - 1));

    assign cmd.valid = (state == bridge_if_pkg::rd_cmd) || (state == bridge_if_pkg::wr_cmd);
    assign cmd.write = (state == bridge_if_pkg::wr_cmd);
    assign cmd.addr  = line_addr;

    always_comb begin
        state_next = state;
        case (state)
            bridge_if_pkg::idle: begin
                if (req.valid) begin
                    state_next = req.write ? bridge_if_pkg::wr_cmd : bridge_if_pkg::rd_cmd;
                end
            end
            bridge_if_pkg::rd_cmd:   state_next = bridge_if_pkg::rd_beats;
            bridge_if_pkg::wr_cmd:   state_next = bridge_if_pkg::wr_beats;
            bridge_if_pkg::rd_beats,
            bridge_if_pkg::wr_beats: begin
                if (beat_step && last_beat) begin
                    state_next = bridge_if_pkg::respond;
                end
            end
            bridge_if_pkg::respond:  state_next = bridge_if_pkg::idle;
            default:                 state_next = bridge_if_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= bridge_if_pkg::idle;
            beat_idx <= '0;
        end else begin
            state <= state_next;
            if (line_load) begin
                beat_idx <= '0;
            end else if (beat_step) begin
                beat_idx <= beat_idx + 1'b1; // wraps to 0 after last beat
            end
        end
    end

    // line aligned address, held for the command cycle
    always_ff @(posedge clk) begin
        if (line_load) begin
            line_addr <= {req.addr[$bits(mem_types_pkg::addr_t)-1:mem_types_pkg::LINE_OFFSET_BITS],
                          {mem_types_pkg::LINE_OFFSET_BITS{1'b0}}};
        end
    end

endmodule

//--- source/line_assembler.sv
module line_assembler (
    input  logic                      clk,
    input  logic                      rst,
    input  bridge_if_pkg::mem_rbeat_t rbeat,
    input  mem_types_pkg::beat_idx_t  beat_idx,
    output mem_types_pkg::line_t      rdata
);
    // beat n lands in 64 bit slice n
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (rbeat.valid) begin
            rdata[beat_idx*$bits(mem_types_pkg::beat_t) +: $bits(mem_types_pkg::beat_t)]
                <= rbeat.data;
        end
    end

endmodule

//--- source/line_splitter.sv
module line_splitter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     line_load,
    input  mem_types_pkg::line_t     wdata,
    input  mem_types_pkg::beat_idx_t beat_idx,
    output mem_types_pkg::beat_t     beat_data
);
    mem_types_pkg::line_t line_q;

    // held copy, the cache may change its request data after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (line_load) begin
            line_q <= wdata;
        end
    end

    assign beat_data =
        line_q[beat_idx*$bits(mem_types_pkg::beat_t) +: $bits(mem_types_pkg::beat_t)];

endmodule

//--- source/mem_types_pkg.sv
package mem_types_pkg;

    // address and data widths
    typedef logic [31:0]  addr_t;
    typedef logic [255:0] line_t;
    typedef logic [63:0]  beat_t;

    // position of a beat inside a line, lowest beat is 0
    typedef logic [1:0] beat_idx_t;

    // write beat credits held by the bridge
    typedef logic [2:0] credit_t;

    localparam int BEATS_PER_LINE = 4;

    // low address bits cleared for a line-aligned address
    localparam int LINE_OFFSET_BITS = 5;

    // credits granted by memory after reset, equals its write buffer depth
    localparam credit_t WRITE_CREDITS = 3'd2;

endpackage

//--- source/write_credit_counter.sv
module write_credit_counter (
    input  logic clk,
    input  logic rst,
    input  logic spend,
    input  logic credit_return,
    output logic credit_avail
);
    mem_types_pkg::credit_t balance;

    always_ff @(posedge clk) begin
        if (rst) begin
            balance <= mem_types_pkg::WRITE_CREDITS;
        end else begin
            case ({spend, credit_return})
                2'b10:   balance <= balance - mem_types_pkg::credit_t'(1);
                2'b01:   balance <= balance + mem_types_pkg::credit_t'(1);
                default: balance <= balance; // both or neither cancel out
            endcase
        end
    end

    assign credit_avail = (balance != '0);

endmodule

//--- tb/burst_mem_model.sv
module burst_mem_model (
    input  logic                      clk,
    input  logic                      rst,
    input  bridge_if_pkg::mem_cmd_t   cmd,
    input  bridge_if_pkg::mem_wbeat_t wbeat,
    input  logic                      hold_drain,
    output logic                      credit_return,
    output bridge_if_pkg::mem_rbeat_t rbeat,
    output mem_types_pkg::credit_t    buf_level,
    output logic                      overflow,
    output logic [31:0]               lines_written,
    output mem_types_pkg::line_t      last_line
);
    timeunit 1ns;
    timeprecision 1ns;

    mem_types_pkg::line_t     store [mem_types_pkg::addr_t];
    mem_types_pkg::addr_t     waddr;
    mem_types_pkg::line_t     wline;
    mem_types_pkg::beat_idx_t wbeat_n;
    mem_types_pkg::line_t     rline;
    mem_types_pkg::beat_idx_t rbeat_n;
    logic                     rd_active;
    logic [2:0]               rd_wait;
    logic [1:0]               drain_wait;
    logic [31:0]              rand_state;
    logic                     take_beat;
    logic                     drain_now;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // content of a line that was never written
    function automatic mem_types_pkg::line_t initial_line(input mem_types_pkg::addr_t a);
        mem_types_pkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = a ^ (32'h9E37_79B9 * 32'(i + 1));
        end
        return l;
    endfunction

    assign take_beat = wbeat.valid && (buf_level != mem_types_pkg::WRITE_CREDITS);
    assign drain_now = (buf_level != '0) && !hold_drain && (drain_wait == '0);

    always @(posedge clk) begin
        if (rst) begin
            rand_state    <= 32'd29705;
            credit_return <= 1'b0;
            rbeat         <= '0;
            buf_level     <= '0;
            overflow      <= 1'b0;
            lines_written <= '0;
            last_line     <= '0;
            waddr         <= '0;
            wline         <= '0;
            wbeat_n       <= '0;
            rline         <= '0;
            rbeat_n       <= '0;
            rd_active     <= 1'b0;
            rd_wait       <= '0;
            drain_wait    <= '0;
        end else begin
            rand_state    <= lcg_step(rand_state);
            credit_return <= drain_now; // one credit back per drained slot
            rbeat.valid   <= 1'b0;

            if (cmd.valid && cmd.write) begin
                waddr   <= cmd.addr;
                wbeat_n <= '0;
            end else if (cmd.valid) begin
                rline     <= store.exists(cmd.addr) ? store[cmd.addr] : initial_line(cmd.addr);
                rbeat_n   <= '0;
                rd_active <= 1'b1;
                rd_wait   <= rand_state[18:16]; // first beat latency
            end

            if (wbeat.valid && !take_beat) begin
                overflow <= 1'b1;
                $display("memory model: write beat arrived while the write buffer was full");
            end
            if (take_beat) begin
                wline[wbeat_n*64 +: 64] <= wbeat.data;
                wbeat_n                 <= wbeat_n + 2'd1;
                if (wbeat_n == 2'd3) begin
                    store[waddr] = {wbeat.data, wline[191:0]};
                    last_line     <= {wbeat.data, wline[191:0]};
                    lines_written <= lines_written + 32'd1;
                end
            end

            case ({take_beat, drain_now})
                2'b10:   buf_level <= buf_level + 3'd1;
                2'b01:   buf_level <= buf_level - 3'd1;
                default: buf_level <= buf_level;
            endcase
            if (drain_now) begin
                drain_wait <= rand_state[21:20];
            end else if ((buf_level != '0) && !hold_drain) begin
                drain_wait <= drain_wait - 2'd1;
            end

            if (rd_active) begin
                if (rd_wait != '0) begin
                    rd_wait <= rd_wait - 3'd1;
                end else begin
                    rbeat.valid <= 1'b1;
                    rbeat.data  <= rline[rbeat_n*64 +: 64];
                    rbeat_n     <= rbeat_n + 2'd1;
                    rd_wait     <= {1'b0, rand_state[25:24]}; // gap before next beat
                    rd_active   <= (rbeat_n != 2'd3);
                end
            end
        end
    end

endmodule

//--- tb/tb_burst_bridge.sv
module tb_burst_bridge;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 5;
    localparam int RESET_CYCLES     = 8;
    localparam int RANDOM_TXNS      = 24;
    localparam int TXN_COUNT        = 6 + RANDOM_TXNS;
    localparam int WORST_TXN_CYCLES = 80;
    localparam int WATCHDOG_NS      =
        (RESET_CYCLES + TXN_COUNT * WORST_TXN_CYCLES) * CLK_PERIOD;

    logic                      clk;
    logic                      rst;
    bridge_if_pkg::line_req_t  req;
    logic                      req_ready;
    bridge_if_pkg::line_resp_t resp;
    bridge_if_pkg::mem_cmd_t   cmd;
    bridge_if_pkg::mem_wbeat_t wbeat;
    logic                      credit_return;
    bridge_if_pkg::mem_rbeat_t rbeat;
    logic                      hold_drain;
    mem_types_pkg::credit_t    buf_level;
    logic                      overflow;
    logic [31:0]               lines_written;
    mem_types_pkg::line_t      last_line;

    // bus activity collected at each rising edge
    int                        resp_count = 0;
    mem_types_pkg::line_t      resp_line = '0;
    int                        cmd_count = 0;
    bridge_if_pkg::mem_cmd_t   last_cmd = '0;
    mem_types_pkg::beat_t      wbeats_seen[$];

    mem_types_pkg::line_t      ref_store [mem_types_pkg::addr_t];
    logic [31:0]               rand_state = 32'd29705;

    burst_bridge_top DUT (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_ready     (req_ready),
        .resp          (resp),
        .cmd           (cmd),
        .wbeat         (wbeat),
        .credit_return (credit_return),
        .rbeat         (rbeat)
    );

    burst_mem_model mem_model (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .wbeat         (wbeat),
        .hold_drain    (hold_drain),
        .credit_return (credit_return),
        .rbeat         (rbeat),
        .buf_level     (buf_level),
        .overflow      (overflow),
        .lines_written (lines_written),
        .last_line     (last_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before the tests finished");
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (resp.valid) begin
                resp_count++;
                resp_line = resp.rdata;
            end
            if (cmd.valid) begin
                cmd_count++;
                last_cmd = cmd;
            end
            if (wbeat.valid) begin
                wbeats_seen.push_back(wbeat.data);
            end
            if (overflow) begin
                stop_on_error("memory model got a write beat with its buffer full");
            end
        end
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] want);
        if (got !== want) begin
            stop_on_error($sformatf("mismatch %s got %0h expected %0h", name, got, want));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic mem_types_pkg::line_t random_line();
        mem_types_pkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = next_rand();
        end
        return l;
    endfunction

    function automatic mem_types_pkg::addr_t line_base(input mem_types_pkg::addr_t a);
        return a & 32'hFFFF_FFE0;
    endfunction

    // lines never written hold a pattern of their own address
    function automatic mem_types_pkg::line_t fill_pattern(input mem_types_pkg::addr_t a);
        mem_types_pkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = a ^ (32'h9E37_79B9 * 32'(i + 1));
        end
        return l;
    endfunction

    function automatic mem_types_pkg::line_t expected_line(input mem_types_pkg::addr_t a);
        if (ref_store.exists(a)) begin
            return ref_store[a];
        end
        return fill_pattern(a);
    endfunction

    task automatic drive_request(input logic write, input mem_types_pkg::addr_t addr,
                                 input mem_types_pkg::line_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        while (!req_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = data;
        @(posedge clk); // accepted here
        #DRIVE_DELAY;
        req.valid = 1'b0;
        req.wdata = ~data; // bridge must keep its own copy
    endtask

    task automatic finish_txn(input int resp_before);
        while (resp_count == resp_before) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk); // room for a stray second pulse
        check_value("resp.valid pulses", 256'(resp_count), 256'(resp_before + 1));
    endtask

    task automatic check_cmd(input int cmd_before, input logic write,
                             input mem_types_pkg::addr_t addr);
        check_value("cmd count", 256'(cmd_count), 256'(cmd_before + 1));
        check_value("cmd.write", 256'(last_cmd.write), 256'(write));
        check_value("cmd.addr", 256'(last_cmd.addr), 256'(line_base(addr)));
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("req_ready", 256'(req_ready), 256'(1'b1));
        check_value("cmd.valid", 256'(cmd.valid), 256'(1'b0));
        check_value("wbeat.valid", 256'(wbeat.valid), 256'(1'b0));
        check_value("resp.valid", 256'(resp.valid), 256'(1'b0));
    endtask

    task automatic read_line_check(input mem_types_pkg::addr_t addr);
        int resp_before;
        int cmd_before;
        resp_before = resp_count;
        cmd_before  = cmd_count;
        drive_request(1'b0, addr, random_line());
        finish_txn(resp_before);
        check_cmd(cmd_before, 1'b0, addr);
        check_value("resp.rdata", resp_line, expected_line(line_base(addr)));
    endtask

    task automatic write_line_check(input mem_types_pkg::addr_t addr,
                                    input mem_types_pkg::line_t data, input bit hold_credits);
        int resp_before;
        int cmd_before;
        int first_beat;
        int written_before;
        if (hold_credits) begin
            while (buf_level != '0) begin
                @(negedge clk);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            hold_drain = 1'b1;
        end
        resp_before    = resp_count;
        cmd_before     = cmd_count;
        first_beat     = wbeats_seen.size();
        written_before = lines_written;
        drive_request(1'b1, addr, data);
        if (hold_credits) begin
            repeat (12) @(negedge clk);
            check_value("wbeat count with credits held",
                        256'(wbeats_seen.size() - first_beat),
                        256'(mem_types_pkg::WRITE_CREDITS));
            check_value("resp count with credits held", 256'(resp_count), 256'(resp_before));
            @(posedge clk);
            #DRIVE_DELAY;
            hold_drain = 1'b0;
        end
        finish_txn(resp_before);
        check_cmd(cmd_before, 1'b1, addr);
        check_value("wbeat count", 256'(wbeats_seen.size() - first_beat),
                    256'(mem_types_pkg::BEATS_PER_LINE));
        for (int i = 0; i < mem_types_pkg::BEATS_PER_LINE; i++) begin
            check_value($sformatf("wbeat.data %0d", i), 256'(wbeats_seen[first_beat + i]),
                        256'(data[i*64 +: 64]));
        end
        check_value("model lines written", 256'(lines_written), 256'(written_before + 1));
        check_value("model stored line", last_line, data);
        ref_store[line_base(addr)] = data;
    endtask

    task automatic write_read_check(input mem_types_pkg::addr_t addr);
        mem_types_pkg::line_t data;
        data = random_line();
        write_line_check(addr, data, 1'b0);
        read_line_check(addr + 32'h18); // same line, other offset
        check_value("read after write", resp_line, data);
    endtask

    task automatic random_traffic(input int count);
        logic [31:0]          r;
        mem_types_pkg::addr_t addr;
        for (int n = 0; n < count; n++) begin
            r    = next_rand();
            addr = 32'h0001_0000 | ((r >> 12) & 32'h0000_01FF);
            if (r[29]) begin
                write_line_check(addr, random_line(), 1'b0);
            end else begin
                read_line_check(addr);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = '0;
        hold_drain = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_reset_state();
        read_line_check(32'h0000_1234);
        read_line_check(32'h8000_0047);
        write_line_check(32'h0000_2017, random_line(), 1'b0);
        write_line_check(32'h0000_3000, random_line(), 1'b1);
        write_read_check(32'h0000_4000);
        random_traffic(RANDOM_TXNS);
        $display("TEST PASS");
        $finish;
    end

endmodule
